// ==== multi_uart_rx.f ====
+incdir+logic
logic/uart_rx_pkg.sv
logic/rx_byte_if.sv
logic/rx_line_sync.sv
logic/rx_deframer.sv
logic/rx_lane_collector.sv
logic/multi_uart_rx.sv
verif/multi_uart_rx_tb.sv

// ==== Bender.yml ====
package:
  name: multi_uart_rx

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_rx_pkg.sv
      - logic/rx_byte_if.sv
      - logic/rx_line_sync.sv
      - logic/rx_deframer.sv
      - logic/rx_lane_collector.sv
      - logic/multi_uart_rx.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/multi_uart_rx_tb.sv

// ==== verif/multi_uart_rx_tb.sv ====
// Testbench for the four-lane UART receiver: LCG, serial line drivers, credit consumer, scoreboard.
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module multi_uart_rx_tb;

    localparam int          CLK_PERIOD  = 40;
    localparam logic [31:0] SEED        = 32'd96140;
    localparam int          WAIT_LIMIT  = 40000;

    logic                      uart_bit_clk_x16;
    logic                      reset_n;
    logic [`UART_RX_LANES-1:0] rx;
    logic                      credit_return;
    logic                      out_valid;
    uart_rx_pkg::byte_t        out_data;
    uart_rx_pkg::lane_idx_t    out_lane;
    logic                      out_frame_err;
    logic                      out_overrun;

    // Expected bytes per lane, packed as {overrun, frame_err, data}.
    logic [9:0] exp_q [`UART_RX_LANES][$];

    // Consumer bookkeeping. Each entry of return_q is the cycle at which a credit may go back.
    int unsigned return_q [$];
    int unsigned cycle;
    int          outstanding;
    logic        hold_credits;
    logic [31:0] stim_seed;
    logic [31:0] credit_seed;
    logic [31:0] burst_seed [`UART_RX_LANES];

    multi_uart_rx u_multi_uart_rx (
        .uart_bit_clk_x16 (uart_bit_clk_x16),
        .reset_n          (reset_n),
        .rx               (rx),
        .credit_return    (credit_return),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_lane         (out_lane),
        .out_frame_err    (out_frame_err),
        .out_overrun      (out_overrun)
    );

    initial begin
        uart_bit_clk_x16 = 1'b0;
        forever #(CLK_PERIOD / 2) uart_bit_clk_x16 = ~uart_bit_clk_x16;
    end

    // One step of a 32-bit linear congruential generator; the upper bits are the useful ones.
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Draws from the main stimulus stream, which only the main thread uses.
    function automatic int unsigned random_below(input int unsigned n);
        stim_seed = lcg_step(stim_seed);
        return stim_seed[31:16] % n;
    endfunction

    function automatic int pending_total();
        int total;
        total = 0;
        for (int l = 0; l < `UART_RX_LANES; l++) begin
            total += exp_q[l].size();
        end
        return total;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge uart_bit_clk_x16);
    endtask

    // Holds one lane at a level for a full bit period of oversample clocks.
    task automatic drive_bit(input int lane, input logic value);
        for (int c = 0; c < `UART_RX_OVERSAMPLE; c++) begin
            @(negedge uart_bit_clk_x16);
            rx[lane] = value;
        end
    endtask

    // One 8N1 frame, LSB first. A low stop bit is followed by one idle bit so the line recovers.
    task automatic send_frame(input int lane, input uart_rx_pkg::byte_t data,
                              input int stop_bits, input logic stop_low);
        drive_bit(lane, 1'b0);
        for (int i = 0; i < `UART_RX_DATA_BITS; i++) begin
            drive_bit(lane, data[i]);
        end
        for (int s = 0; s < stop_bits; s++) begin
            drive_bit(lane, !stop_low);
        end
        if (stop_low) begin
            drive_bit(lane, 1'b1);
        end
    endtask

    // A break is the line held low for many bit times, then released.
    task automatic send_break(input int lane, input int bit_times);
        for (int b = 0; b < bit_times; b++) begin
            drive_bit(lane, 1'b0);
        end
        drive_bit(lane, 1'b1);
        drive_bit(lane, 1'b1);
    endtask

    // Pulls the line low for fewer cycles than a start bit needs.
    task automatic glitch_line(input int lane, input int low_cycles);
        repeat (low_cycles) begin
            @(negedge uart_bit_clk_x16);
            rx[lane] = 1'b0;
        end
        @(negedge uart_bit_clk_x16);
        rx[lane] = 1'b1;
    endtask

    task automatic expect_byte(input int lane, input uart_rx_pkg::byte_t data,
                               input logic frame_err, input logic overrun);
        exp_q[lane].push_back({overrun, frame_err, data});
    endtask

    // Clean frames on one lane, each with one or two stop bits, from a private LCG stream.
    task automatic lane_burst(input int lane, input logic [31:0] seed);
        logic [31:0]        s;
        uart_rx_pkg::byte_t data;
        s = seed;
        for (int n = 0; n < 4; n++) begin
            s    = lcg_step(s);
            data = s[23:16];
            expect_byte(lane, data, 1'b0, 1'b0);
            send_frame(lane, data, s[31] ? 2 : 1, 1'b0);
            idle_cycles(int'(s[30:27]));
        end
    endtask

    // Compares one output beat with the head of its lane's queue.
    task automatic check_output();
        int         lane;
        logic [9:0] head;
        assert (!$isunknown(out_lane))
            else report_failure("out_lane is unknown while out_valid is high");
        lane = int'(out_lane);
        assert (exp_q[lane].size() > 0)
            else report_failure($sformatf("unexpected byte %h on lane %0d at %0t",
                                          out_data, lane, $time));
        head = exp_q[lane].pop_front();
        assert (out_data == head[7:0])
            else report_failure($sformatf("[FAIL] %0t out_data lane %0d expected %h got %h",
                                          $time, lane, head[7:0], out_data));
        assert (out_frame_err == head[8])
            else report_failure($sformatf("[FAIL] %0t out_frame_err lane %0d expected %b got %b",
                                          $time, lane, head[8], out_frame_err));
        assert (out_overrun == head[9])
            else report_failure($sformatf("[FAIL] %0t out_overrun lane %0d expected %b got %b",
                                          $time, lane, head[9], out_overrun));
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (pending_total() != 0 && t < WAIT_LIMIT) begin
            @(negedge uart_bit_clk_x16);
            t++;
        end
        assert (pending_total() == 0)
            else report_failure($sformatf("timed out with %0d expected bytes never delivered",
                                          pending_total()));
    endtask

    task automatic wait_credits_home();
        int t;
        t = 0;
        while ((outstanding != 0 || return_q.size() != 0) && t < WAIT_LIMIT) begin
            @(negedge uart_bit_clk_x16);
            t++;
        end
        assert (outstanding == 0 && return_q.size() == 0)
            else report_failure("timed out waiting for all output credits to return");
    endtask

    // Consumer. Outputs are registered on the rising edge, so the falling edge sees them stable.
    // Each accepted beat books a credit return 0 to 5 cycles later unless returns are withheld.
    initial begin
        int unsigned delay;
        credit_return = 1'b0;
        credit_seed   = SEED;
        cycle         = 0;
        outstanding   = 0;
        forever begin
            @(negedge uart_bit_clk_x16);
            cycle++;
            credit_return = 1'b0;
            if (reset_n && out_valid) begin
                check_output();
                outstanding++;
                assert (outstanding <= `UART_RX_OUT_CREDITS)
                    else report_failure($sformatf("[FAIL] %0t outstanding limit %0d got %0d",
                                                  $time, `UART_RX_OUT_CREDITS, outstanding));
                credit_seed = lcg_step(credit_seed);
                delay       = credit_seed[31:16] % 6;
                return_q.push_back(cycle + delay);
            end
            if (!hold_credits && return_q.size() > 0 && return_q[0] <= cycle) begin
                void'(return_q.pop_front());
                credit_return = 1'b1;
                outstanding--;
            end
        end
    end

    initial begin
        int                 lane;
        int                 other;
        int                 t;
        uart_rx_pkg::byte_t data;
        rx           = '1;
        reset_n      = 1'b0;
        hold_credits = 1'b0;
        stim_seed    = SEED;
        repeat (2) @(negedge uart_bit_clk_x16);
        reset_n = 1'b1;
        idle_cycles(20);

        // Random bytes on one lane with a single stop bit and random gaps.
        lane = random_below(`UART_RX_LANES);
        for (int n = 0; n < 8; n++) begin
            data = uart_rx_pkg::byte_t'(random_below(256));
            expect_byte(lane, data, 1'b0, 1'b0);
            send_frame(lane, data, 1, 1'b0);
            idle_cycles(random_below(24));
        end

        // All lanes at once; seeds are drawn before the fork so the streams stay fixed.
        for (int l = 0; l < `UART_RX_LANES; l++) begin
            burst_seed[l] = lcg_step(stim_seed ^ l);
            stim_seed     = lcg_step(stim_seed);
        end
        fork
            lane_burst(0, burst_seed[0]);
            lane_burst(1, burst_seed[1]);
            lane_burst(2, burst_seed[2]);
            lane_burst(3, burst_seed[3]);
        join

        // Low stop bit, then a long break, then a clean frame on the same lane.
        lane = random_below(`UART_RX_LANES);
        data = uart_rx_pkg::byte_t'(random_below(256));
        expect_byte(lane, data, 1'b1, 1'b0);
        send_frame(lane, data, 1, 1'b1);
        idle_cycles(3 * `UART_RX_OVERSAMPLE);
        expect_byte(lane, '0, 1'b1, 1'b0);
        send_break(lane, 30);
        data = uart_rx_pkg::byte_t'(random_below(256));
        expect_byte(lane, data, 1'b0, 1'b0);
        send_frame(lane, data, 1, 1'b0);

        // A short low pulse must not be taken for a start bit.
        lane = random_below(`UART_RX_LANES);
        glitch_line(lane, 1 + random_below(7));
        idle_cycles(2 * `UART_RX_OVERSAMPLE);

        // Exhaust the credits with filler bytes, then send two frames on another lane.
        // The second frame lands on a full holding register and is dropped.
        wait_drained();
        wait_credits_home();
        hold_credits = 1'b1;
        lane  = random_below(`UART_RX_LANES);
        other = (lane + 1 + random_below(`UART_RX_LANES - 1)) % `UART_RX_LANES;
        for (int n = 0; n < `UART_RX_OUT_CREDITS; n++) begin
            data = uart_rx_pkg::byte_t'(random_below(256));
            expect_byte(lane, data, 1'b0, 1'b0);
            send_frame(lane, data, 1, 1'b0);
        end
        data = uart_rx_pkg::byte_t'(random_below(256));
        expect_byte(other, data, 1'b0, 1'b1);
        send_frame(other, data, 1, 1'b0);
        send_frame(other, uart_rx_pkg::byte_t'(random_below(256)), 1, 1'b0);
        idle_cycles(`UART_RX_OVERSAMPLE);
        hold_credits = 1'b0;

        // Drain, then idle long enough for any stray byte to show up.
        t = 0;
        while (pending_total() != 0 && t < WAIT_LIMIT) begin
            @(negedge uart_bit_clk_x16);
            t++;
        end
        idle_cycles(400);
        if (pending_total() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure($sformatf("timed out with %0d expected bytes never delivered",
                                     pending_total()));
        end
    end

endmodule

`default_nettype wire

// ==== logic/multi_uart_rx.sv ====
// Top level of the four-lane UART receiver: line synchronizer, per-lane deframers and collector.
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module multi_uart_rx (
    input  logic                      uart_bit_clk_x16,
    input  logic                      reset_n,
    input  logic [`UART_RX_LANES-1:0] rx,
    input  logic                      credit_return,
    output logic                      out_valid,
    output uart_rx_pkg::byte_t        out_data,
    output uart_rx_pkg::lane_idx_t    out_lane,
    output logic                      out_frame_err,
    output logic                      out_overrun
);

    // Serial lines after the two-stage synchronizer.
    logic [`UART_RX_LANES-1:0] rx_sync;

    // One holding-register link per lane between deframer and collector.
    rx_byte_if lane_if [`UART_RX_LANES] ();

    rx_line_sync u_rx_line_sync (
        .uart_bit_clk_x16 (uart_bit_clk_x16),
        .reset_n          (reset_n),
        .rx               (rx),
        .rx_sync          (rx_sync)
    );

    // Identical deframers, one per serial lane.
    for (genvar g = 0; g < `UART_RX_LANES; g++) begin : g_deframer
        rx_deframer u_rx_deframer (
            .uart_bit_clk_x16 (uart_bit_clk_x16),
            .reset_n          (reset_n),
            .rx_sync          (rx_sync[g]),
            .byte_out         (lane_if[g])
        );
    end

    rx_lane_collector u_rx_lane_collector (
        .uart_bit_clk_x16 (uart_bit_clk_x16),
        .reset_n          (reset_n),
        .lanes            (lane_if),
        .credit_return    (credit_return),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_lane         (out_lane),
        .out_frame_err    (out_frame_err),
        .out_overrun      (out_overrun)
    );

endmodule

`default_nettype wire

// ==== logic/rx_lane_collector.sv ====
// Round-robin collector that drains the lane holding registers onto one credit-controlled output.
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module rx_lane_collector (
    input  logic                   uart_bit_clk_x16,
    input  logic                   reset_n,
    rx_byte_if.collector           lanes [`UART_RX_LANES],
    input  logic                   credit_return,
    output logic                   out_valid,
    output uart_rx_pkg::byte_t     out_data,
    output uart_rx_pkg::lane_idx_t out_lane,
    output logic                   out_frame_err,
    output logic                   out_overrun
);

    // Flattened copies of the lane interfaces, so a variable index can select them.
    logic [`UART_RX_LANES-1:0] held_vec;
    logic [`UART_RX_LANES-1:0] frame_err_vec;
    logic [`UART_RX_LANES-1:0] overrun_vec;
    logic [`UART_RX_LANES-1:0] take_vec;
    uart_rx_pkg::byte_t        data_arr [`UART_RX_LANES];

    // Lane granted most recently; the search starts just after it.
    uart_rx_pkg::lane_idx_t last_grant;
    uart_rx_pkg::lane_idx_t pick;
    logic                   pick_ok;

    uart_rx_pkg::credit_t credit_cnt;
    logic                 issue;

    for (genvar g = 0; g < `UART_RX_LANES; g++) begin : g_lane
        assign held_vec[g]      = lanes[g].held;
        assign frame_err_vec[g] = lanes[g].frame_err;
        assign overrun_vec[g]   = lanes[g].overrun;
        assign data_arr[g]      = lanes[g].data;
        assign lanes[g].take    = take_vec[g];
        assign take_vec[g]      = issue && (pick == uart_rx_pkg::lane_idx_t'(g));
    end

    // Round-robin search over all lanes, starting one past the last grant.
    // The last granted lane is checked last, so it only wins when alone.
    always_comb begin
        uart_rx_pkg::lane_idx_t cand;
        cand    = last_grant;
        pick    = last_grant;
        pick_ok = 1'b0;
        for (int off = 1; off <= `UART_RX_LANES; off++) begin
            cand = uart_rx_pkg::lane_idx_t'((int'(last_grant) + off) % `UART_RX_LANES);
            if (!pick_ok && held_vec[cand]) begin
                pick    = cand;
                pick_ok = 1'b1;
            end
        end
    end

    // A byte issued this cycle shows up as out_valid next cycle and spends a
    // credit then, so the one in flight is reserved before issuing another.
    assign issue = pick_ok && (credit_cnt > uart_rx_pkg::credit_t'(out_valid));

    always_ff @(posedge uart_bit_clk_x16 or negedge reset_n) begin
        if (!reset_n) begin
            out_valid  <= 1'b0;
            credit_cnt <= uart_rx_pkg::credit_t'(`UART_RX_OUT_CREDITS);
            // Start the pointer on the top lane so lane 0 is searched first.
            last_grant <= uart_rx_pkg::lane_idx_t'(`UART_RX_LANES - 1);
        end else begin
            out_valid  <= issue;
            credit_cnt <= credit_cnt - uart_rx_pkg::credit_t'(out_valid)
                        + uart_rx_pkg::credit_t'(credit_return);
            if (issue) begin
                last_grant <= pick;
            end
        end
    end

    // Output fields are captured together with the pop of the lane.
    always_ff @(posedge uart_bit_clk_x16) begin
        if (issue) begin
            out_data      <= data_arr[pick];
            out_lane      <= pick;
            out_frame_err <= frame_err_vec[pick];
            out_overrun   <= overrun_vec[pick];
        end
    end

    // The consumer never returns more credits than it was given.
    a_credit_bounded : assert property (
        @(posedge uart_bit_clk_x16) disable iff (!reset_n)
        credit_cnt <= uart_rx_pkg::credit_t'(`UART_RX_OUT_CREDITS)
    ) else $error("rx_lane_collector: credit count above depth");

    // Every issued byte must have had a credit waiting for it.
    a_valid_needs_credit : assert property (
        @(posedge uart_bit_clk_x16) disable iff (!reset_n)
        out_valid |-> (credit_cnt != '0)
    ) else $error("rx_lane_collector: out_valid with no credit");

endmodule

`default_nettype wire

// ==== logic/rx_deframer.sv ====
// Per-lane 8N1 deframer FSM with a one-byte holding register, frame error and overrun flags.
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module rx_deframer (
    input  logic          uart_bit_clk_x16,
    input  logic          reset_n,
    input  logic          rx_sync,
    rx_byte_if.deframer   byte_out
);

    // Last count of a full bit period, where a data or stop bit is sampled.
    localparam uart_rx_pkg::sample_cnt_t BIT_LAST =
        uart_rx_pkg::sample_cnt_t'(`UART_RX_OVERSAMPLE - 1);

    // Last count of half a bit period; the start bit is confirmed here.
    localparam uart_rx_pkg::sample_cnt_t START_LAST =
        uart_rx_pkg::sample_cnt_t'(`UART_RX_OVERSAMPLE / 2 - 1);

    // Index of the final data bit.
    localparam uart_rx_pkg::bit_idx_t BIT_IDX_LAST =
        uart_rx_pkg::bit_idx_t'(`UART_RX_DATA_BITS - 1);

    uart_rx_pkg::deframe_state_t state;
    uart_rx_pkg::sample_cnt_t    sample_cnt;
    uart_rx_pkg::bit_idx_t       bit_idx;
    uart_rx_pkg::byte_t          shift_reg;

    // Sample strobes at the middle of a data bit and of the stop bit.
    logic bit_sample;
    logic stop_sample;

    // A finished frame is either stored or dropped.
    logic load_hold;
    logic drop_byte;

    assign bit_sample  = (state == uart_rx_pkg::ST_DATA) && (sample_cnt == BIT_LAST);
    assign stop_sample = (state == uart_rx_pkg::ST_STOP) && (sample_cnt == BIT_LAST);

    // A pop on the same edge frees the register, so the new byte still fits.
    assign load_hold = stop_sample && (!byte_out.held || byte_out.take);
    assign drop_byte = stop_sample && byte_out.held && !byte_out.take;

    // Receive FSM.
    // The counter restarts at every sample point, so each sample lands one
    // full bit period after the previous one.
    always_ff @(posedge uart_bit_clk_x16 or negedge reset_n) begin
        if (!reset_n) begin
            state      <= uart_rx_pkg::ST_IDLE;
            sample_cnt <= '0;
            bit_idx    <= '0;
        end else begin
            unique case (state)
                uart_rx_pkg::ST_IDLE: begin
                    // The first low cycle already counts towards the start bit.
                    if (!rx_sync) begin
                        state      <= uart_rx_pkg::ST_START;
                        sample_cnt <= uart_rx_pkg::sample_cnt_t'(1);
                    end
                end
                uart_rx_pkg::ST_START: begin
                    // A line that rises before mid-bit was a glitch.
                    if (rx_sync) begin
                        state <= uart_rx_pkg::ST_IDLE;
                    end else if (sample_cnt == START_LAST) begin
                        state      <= uart_rx_pkg::ST_DATA;
                        sample_cnt <= '0;
                        bit_idx    <= '0;
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
                uart_rx_pkg::ST_DATA: begin
                    sample_cnt <= sample_cnt + 1'b1;
                    if (bit_sample) begin
                        sample_cnt <= '0;
                        bit_idx    <= bit_idx + 1'b1;
                        if (bit_idx == BIT_IDX_LAST) begin
                            state <= uart_rx_pkg::ST_STOP;
                        end
                    end
                end
                uart_rx_pkg::ST_STOP: begin
                    sample_cnt <= sample_cnt + 1'b1;
                    if (stop_sample) begin
                        sample_cnt <= '0;
                        // A low stop bit may be a break; wait for the line to recover.
                        state <= rx_sync ? uart_rx_pkg::ST_IDLE : uart_rx_pkg::ST_WAIT_IDLE;
                    end
                end
                uart_rx_pkg::ST_WAIT_IDLE: begin
                    if (rx_sync) begin
                        state <= uart_rx_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= uart_rx_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Data path.
    // Bits shift in from the top, so after eight samples the first one sits in bit 0.
    always_ff @(posedge uart_bit_clk_x16) begin
        if (bit_sample) begin
            shift_reg <= {rx_sync, shift_reg[`UART_RX_DATA_BITS-1:1]};
        end
        if (load_hold) begin
            byte_out.data <= shift_reg;
        end
    end

    // Holding register flags.
    // A dropped byte leaves the held byte in place and only marks it overrun.
    always_ff @(posedge uart_bit_clk_x16 or negedge reset_n) begin
        if (!reset_n) begin
            byte_out.held      <= 1'b0;
            byte_out.frame_err <= 1'b0;
            byte_out.overrun   <= 1'b0;
        end else if (load_hold) begin
            byte_out.held      <= 1'b1;
            byte_out.frame_err <= !rx_sync;
            byte_out.overrun   <= 1'b0;
        end else if (drop_byte) begin
            byte_out.overrun <= 1'b1;
        end else if (byte_out.take) begin
            byte_out.held <= 1'b0;
        end
    end

    // The collector must never pop an empty lane.
    a_take_only_when_held : assert property (
        @(posedge uart_bit_clk_x16) disable iff (!reset_n)
        byte_out.take |-> byte_out.held
    ) else $error("rx_deframer: take while holding register is empty");

    // The state register holds one of the five encoded states.
    a_state_legal : assert property (
        @(posedge uart_bit_clk_x16) disable iff (!reset_n)
        !$isunknown(state) && (state inside {uart_rx_pkg::ST_IDLE, uart_rx_pkg::ST_START,
            uart_rx_pkg::ST_DATA, uart_rx_pkg::ST_STOP, uart_rx_pkg::ST_WAIT_IDLE})
    ) else $error("rx_deframer: illegal state encoding");

endmodule

`default_nettype wire

// ==== logic/rx_line_sync.sv ====
// Two-stage synchronizer that brings every asynchronous serial line into the receive clock domain.
`timescale 1ns/100ps
`default_nettype none

`include "uart_rx_macros.svh"

module rx_line_sync (
    input  logic                      uart_bit_clk_x16,
    input  logic                      reset_n,
    input  logic [`UART_RX_LANES-1:0] rx,
    output logic [`UART_RX_LANES-1:0] rx_sync
);

    // First stage catches the raw line and may go metastable.
    logic [`UART_RX_LANES-1:0] rx_meta;

    // Both stages reset to ones.
    // An idle UART line is high, so no lane sees a false start bit
    // while the synchronizer fills after reset.
    always_ff @(posedge uart_bit_clk_x16 or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta <= '1;
            rx_sync <= '1;
        end else begin
            // Second stage gives the first a full cycle to settle.
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // An undriven or floating serial input would reach every deframer two
    // cycles later and could fake a start bit; flag it at the source.
    a_no_x_after_reset : assert property (
        @(posedge uart_bit_clk_x16) disable iff (!reset_n)
        !$isunknown(rx_sync)
    ) else $error("rx_line_sync: synchronized serial line is X");

endmodule

`default_nettype wire

// ==== logic/rx_byte_if.sv ====
// Interface carrying one lane's held byte and its pop strobe, with deframer and collector modports.
`timescale 1ns/100ps
`default_nettype none

interface rx_byte_if;

    // The lane's holding register is full.
    logic held;

    // Received byte, valid while held is high.
    uart_rx_pkg::byte_t data;

    // Stop bit was sampled low for this byte.
    logic frame_err;

    // At least one later byte was dropped while this one waited.
    logic overrun;

    // One-cycle pop; the holding register empties on the edge where it is high.
    logic take;

    // The deframer owns the holding register and only observes the pop.
    modport deframer (
        output held,
        output data,
        output frame_err,
        output overrun,
        input  take
    );

    // The collector reads the holding register and issues the pop.
    modport collector (
        input  held,
        input  data,
        input  frame_err,
        input  overrun,
        output take
    );

endinterface

`default_nettype wire

// ==== logic/uart_rx_pkg.sv ====
// Shared vector typedefs and the deframer state enum for the UART receiver.
`default_nettype none

`include "uart_rx_macros.svh"

package uart_rx_pkg;

    // One received data word.
    typedef logic [`UART_RX_DATA_BITS-1:0] byte_t;

    // Lane number carried with each output byte.
    typedef logic [$clog2(`UART_RX_LANES)-1:0] lane_idx_t;

    // Position inside one bit period, counted in oversample clocks.
    typedef logic [$clog2(`UART_RX_OVERSAMPLE)-1:0] sample_cnt_t;

    // Index of the data bit currently being received.
    typedef logic [$clog2(`UART_RX_DATA_BITS)-1:0] bit_idx_t;

    // Output credit count; it must hold the full depth, so one extra value.
    typedef logic [$clog2(`UART_RX_OUT_CREDITS+1)-1:0] credit_t;

    // Per-lane receive FSM states.
    // ST_WAIT_IDLE holds a lane after a framing error until the line goes high.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP,
        ST_WAIT_IDLE
    } deframe_state_t;

endpackage

`default_nettype wire

// ==== logic/uart_rx_macros.svh ====
// Lane count, oversampling ratio, data width and output credit depth for the UART receiver.
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// Number of independent serial receive lanes.
// The lane index type in the package is sized from this value.
`define UART_RX_LANES 4

// Clock cycles per bit period.
// The receive clock runs at sixteen times the baud rate.
`define UART_RX_OVERSAMPLE 16

// Data bits per frame.
// Frames are 8N1, least significant bit first, no parity.
`define UART_RX_DATA_BITS 8

// Output entries the downstream consumer can absorb.
// The collector starts with this many credits after reset.
`define UART_RX_OUT_CREDITS 4

`endif
